/* Bender.yml */
package:
  name: csr_subsys

sources:
  # packages first, core_pkg uses csr_pkg
  - rtl/csr_pkg.sv
  - rtl/core_pkg.sv
  - rtl/mem_trap_ctrl.sv
  - rtl/clint.sv
  - rtl/mem_csr.sv
  - rtl/csr_subsys_top.sv
  - target: test
    files:
      - testbench/tb_csr_subsys.sv

/* files.f */
rtl/csr_pkg.sv
rtl/core_pkg.sv
rtl/mem_trap_ctrl.sv
rtl/clint.sv
rtl/mem_csr.sv
rtl/csr_subsys_top.sv
testbench/tb_csr_subsys.sv

/* rtl/clint.sv */
`timescale 1ns/1ps

module clint (
    input  logic                        clk,
    input  logic                        rst,
    input  core_pkg::clint_req_t        clint_req_i,
    output logic [core_pkg::XLEN-1:0]   clint_rdata_o,
    output logic                        mtip_o,
    output logic                        mtimecmp_upd_o
);

    logic [core_pkg::XLEN-1:0] mtime_q;
    logic [core_pkg::XLEN-1:0] mtimecmp_q;
    logic                      upd_q;
    logic                      sel_mtime;
    logic                      sel_mtimecmp;
    logic                      bus_wr;
    logic                      bus_rd;

    assign sel_mtime    = clint_req_i.addr == csr_pkg::CLINT_MTIME_ADDR;
    assign sel_mtimecmp = clint_req_i.addr == csr_pkg::CLINT_MTIMECMP_ADDR;
    assign bus_wr       = clint_req_i.valid & clint_req_i.we;
    assign bus_rd       = clint_req_i.valid & ~clint_req_i.we;

    // free running, bus write overrides
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime_q <= '0;
        end else if (bus_wr && sel_mtime) begin
            mtime_q <= clint_req_i.wdata;
        end else begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    // all-ones keeps the timer quiet out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp_q <= '1;
        end else if (bus_wr && sel_mtimecmp) begin
            mtimecmp_q <= clint_req_i.wdata;
        end
    end

    // pulse lines up with the new compare result
    always_ff @(posedge clk) begin
        if (rst) begin
            upd_q <= 1'b0;
        end else begin
            upd_q <= bus_wr & sel_mtimecmp;
        end
    end

    always_comb begin
        clint_rdata_o = '0;
        if (bus_rd && sel_mtime) begin
            clint_rdata_o = mtime_q;
        end else if (bus_rd && sel_mtimecmp) begin
            clint_rdata_o = mtimecmp_q;
        end
    end

    assign mtip_o         = mtime_q >= mtimecmp_q;
    assign mtimecmp_upd_o = upd_q;

endmodule

/* rtl/core_pkg.sv */
package core_pkg;

    localparam int XLEN = 64;
    localparam int CSR_IDX_W = 12;

    // csr request from the memory stage
    typedef struct packed {
        logic                   inst_valid;
        logic [CSR_IDX_W-1:0]   csr_index;
        csr_pkg::csr_op_t       csr_op;
        logic                   src_imm;
        logic [XLEN-1:0]        rs1_data;
        logic [XLEN-1:0]        imm_data;
        logic [XLEN-1:0]        inst_addr;
    } csr_req_t;

    // decoded system instruction flags
    typedef struct packed {
        logic ecall;
        logic ebreak;
        logic mret;
    } inst_flags_t;

    // single-cycle clint bus strobe
    typedef struct packed {
        logic               valid;
        logic               we;
        logic [XLEN-1:0]    addr;
        logic [XLEN-1:0]    wdata;
    } clint_req_t;

endpackage

/* rtl/csr_pkg.sv */
package csr_pkg;

    typedef enum logic [1:0] {
        CSR_NONE = 2'd0,
        CSR_RW   = 2'd1,
        CSR_RS   = 2'd2,
        CSR_RC   = 2'd3
    } csr_op_t;

    // machine csr addresses
    localparam logic [11:0] CSR_MSTATUS   = 12'h300;
    localparam logic [11:0] CSR_MISA      = 12'h301;
    localparam logic [11:0] CSR_MIE       = 12'h304;
    localparam logic [11:0] CSR_MTVEC     = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [11:0] CSR_MEPC      = 12'h341;
    localparam logic [11:0] CSR_MCAUSE    = 12'h342;
    localparam logic [11:0] CSR_MIP       = 12'h344;
    localparam logic [11:0] CSR_MCYCLE    = 12'hB00;
    localparam logic [11:0] CSR_MINSTRET  = 12'hB02;
    localparam logic [11:0] CSR_MVENDORID = 12'hF11;
    localparam logic [11:0] CSR_MARCHID   = 12'hF12;
    localparam logic [11:0] CSR_MIMPID    = 12'hF13;
    localparam logic [11:0] CSR_MHARTID   = 12'hF14;

    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;
    localparam int MSTATUS_FS_LO  = 13;
    localparam int MSTATUS_XS_LO  = 15;
    localparam int MIX_MTI        = 7;

    localparam logic [63:0] CAUSE_ECALL  = 64'd11;
    localparam logic [63:0] CAUSE_EBREAK = 64'd3;
    localparam logic [63:0] CAUSE_MTIMER = 64'h8000_0000_0000_0007;

    // rv64i, mxl = 2
    localparam logic [63:0] MISA_VALUE      = 64'h8000_0000_0000_0100;
    localparam logic [63:0] MARCHID_VALUE   = 64'd1;
    localparam logic [63:0] MVENDORID_VALUE = 64'd0;
    localparam logic [63:0] MIMPID_VALUE    = 64'd0;
    localparam logic [63:0] MHARTID_VALUE   = 64'd0;

    localparam logic [63:0] CLINT_MTIMECMP_ADDR = 64'h0000_0000_0200_4000;
    localparam logic [63:0] CLINT_MTIME_ADDR    = 64'h0000_0000_0200_BFF8;

endpackage

/* rtl/csr_subsys_top.sv */
`timescale 1ns/1ps

module csr_subsys_top (
    input  logic                        clk,
    input  logic                        rst,
    input  core_pkg::csr_req_t          csr_req_i,
    input  core_pkg::inst_flags_t       flags_i,
    input  core_pkg::clint_req_t        clint_req_i,
    output logic [core_pkg::XLEN-1:0]   csr_rdata_o,
    output logic [core_pkg::XLEN-1:0]   clint_rdata_o,
    output logic                        redirect_o,
    output logic [core_pkg::XLEN-1:0]   redirect_pc_o
);

    logic enter_trap;
    logic leave_trap;
    logic irq_pending;
    logic mtip;
    logic mtimecmp_upd;

    mem_trap_ctrl u_mem_trap_ctrl (
        .inst_valid_i  (csr_req_i.inst_valid),
        .ecall_i       (flags_i.ecall),
        .ebreak_i      (flags_i.ebreak),
        .mret_i        (flags_i.mret),
        .irq_pending_i (irq_pending),
        .enter_trap_o  (enter_trap),
        .leave_trap_o  (leave_trap),
        .redirect_o    (redirect_o)
    );

    mem_csr u_mem_csr (
        .clk            (clk),
        .rst            (rst),
        .csr_req_i      (csr_req_i),
        .flags_i        (flags_i),
        .enter_trap_i   (enter_trap),
        .leave_trap_i   (leave_trap),
        .mtip_i         (mtip),
        .mtimecmp_upd_i (mtimecmp_upd),
        .csr_rdata_o    (csr_rdata_o),
        .irq_pending_o  (irq_pending),
        .nxt_pc_o       (redirect_pc_o)
    );

    clint u_clint (
        .clk            (clk),
        .rst            (rst),
        .clint_req_i    (clint_req_i),
        .clint_rdata_o  (clint_rdata_o),
        .mtip_o         (mtip),
        .mtimecmp_upd_o (mtimecmp_upd)
    );

endmodule

/* rtl/mem_csr.sv */
`timescale 1ns/1ps

module mem_csr (
    input  logic                        clk,
    input  logic                        rst,
    input  core_pkg::csr_req_t          csr_req_i,
    input  core_pkg::inst_flags_t       flags_i,
    input  logic                        enter_trap_i,
    input  logic                        leave_trap_i,
    input  logic                        mtip_i,
    input  logic                        mtimecmp_upd_i,
    output logic [core_pkg::XLEN-1:0]   csr_rdata_o,
    output logic                        irq_pending_o,
    output logic [core_pkg::XLEN-1:0]   nxt_pc_o
);

    logic [core_pkg::XLEN-1:0] mstatus_q;
    logic [core_pkg::XLEN-1:0] mie_q;
    logic [core_pkg::XLEN-1:0] mtvec_q;
    logic [core_pkg::XLEN-1:0] mscratch_q;
    logic [core_pkg::XLEN-1:0] mepc_q;
    logic [core_pkg::XLEN-1:0] mcause_q;
    logic [core_pkg::XLEN-1:0] mip_q;
    logic [core_pkg::XLEN-1:0] mcycle_q;
    logic [core_pkg::XLEN-1:0] minstret_q;

    logic [core_pkg::XLEN-1:0] mcycle_inc;
    logic [core_pkg::XLEN-1:0] minstret_inc;
    logic [core_pkg::XLEN-1:0] src;
    logic [core_pkg::XLEN-1:0] old_val;
    logic [core_pkg::XLEN-1:0] new_val;
    logic [core_pkg::XLEN-1:0] mstatus_wr;
    logic [core_pkg::XLEN-1:0] mix_mask;
    logic [core_pkg::XLEN-1:0] trap_cause;
    logic                      csr_we;
    logic                      sd_bit;

    assign mcycle_inc   = mcycle_q + 1'b1;
    assign minstret_inc = minstret_q + 1'b1;
    assign mix_mask     = core_pkg::XLEN'(1) << csr_pkg::MIX_MTI;

    assign csr_we = csr_req_i.inst_valid && (csr_req_i.csr_op != csr_pkg::CSR_NONE);
    assign src    = csr_req_i.src_imm ? csr_req_i.imm_data : csr_req_i.rs1_data;

    always_comb begin
        case (csr_req_i.csr_index)
            csr_pkg::CSR_MSTATUS:   csr_rdata_o = mstatus_q;
            csr_pkg::CSR_MISA:      csr_rdata_o = csr_pkg::MISA_VALUE;
            csr_pkg::CSR_MIE:       csr_rdata_o = mie_q;
            csr_pkg::CSR_MTVEC:     csr_rdata_o = mtvec_q;
            csr_pkg::CSR_MSCRATCH:  csr_rdata_o = mscratch_q;
            csr_pkg::CSR_MEPC:      csr_rdata_o = mepc_q;
            csr_pkg::CSR_MCAUSE:    csr_rdata_o = mcause_q;
            csr_pkg::CSR_MIP:       csr_rdata_o = mip_q;
            csr_pkg::CSR_MCYCLE:    csr_rdata_o = mcycle_q;
            csr_pkg::CSR_MINSTRET:  csr_rdata_o = minstret_q;
            csr_pkg::CSR_MVENDORID: csr_rdata_o = csr_pkg::MVENDORID_VALUE;
            csr_pkg::CSR_MARCHID:   csr_rdata_o = csr_pkg::MARCHID_VALUE;
            csr_pkg::CSR_MIMPID:    csr_rdata_o = csr_pkg::MIMPID_VALUE;
            csr_pkg::CSR_MHARTID:   csr_rdata_o = csr_pkg::MHARTID_VALUE;
            default:                csr_rdata_o = '0;
        endcase
    end

    // counters modify from their incremented value so a set/clear keeps this cycle's tick
    always_comb begin
        case (csr_req_i.csr_index)
            csr_pkg::CSR_MCYCLE:   old_val = mcycle_inc;
            csr_pkg::CSR_MINSTRET: old_val = minstret_inc;
            default:               old_val = csr_rdata_o;
        endcase
    end

    always_comb begin
        case (csr_req_i.csr_op)
            csr_pkg::CSR_RW: new_val = src;
            csr_pkg::CSR_RS: new_val = old_val | src;
            csr_pkg::CSR_RC: new_val = old_val & ~src;
            default:         new_val = old_val;
        endcase
    end

    // sd summarizes dirty fs/xs
    assign sd_bit = (new_val[csr_pkg::MSTATUS_FS_LO +: 2] == 2'b11) ||
                    (new_val[csr_pkg::MSTATUS_XS_LO +: 2] == 2'b11);
    assign mstatus_wr = {sd_bit, new_val[core_pkg::XLEN-2:0]};

    always_comb begin
        if (flags_i.ecall) begin
            trap_cause = csr_pkg::CAUSE_ECALL;
        end else if (flags_i.ebreak) begin
            trap_cause = csr_pkg::CAUSE_EBREAK;
        end else begin
            trap_cause = csr_pkg::CAUSE_MTIMER;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_q <= '0;
        end else if (csr_we && csr_req_i.csr_index == csr_pkg::CSR_MSTATUS) begin
            mstatus_q <= mstatus_wr;
        end else if (enter_trap_i) begin
            mstatus_q[csr_pkg::MSTATUS_MPP_LO +: 2] <= 2'b11;
            mstatus_q[csr_pkg::MSTATUS_MPIE]        <= mstatus_q[csr_pkg::MSTATUS_MIE];
            mstatus_q[csr_pkg::MSTATUS_MIE]         <= 1'b0;
        end else if (leave_trap_i) begin
            mstatus_q[csr_pkg::MSTATUS_MPP_LO +: 2] <= 2'b00;
            mstatus_q[csr_pkg::MSTATUS_MPIE]        <= 1'b1;
            mstatus_q[csr_pkg::MSTATUS_MIE]         <= mstatus_q[csr_pkg::MSTATUS_MPIE];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc_q   <= '0;
            mcause_q <= '0;
        end else begin
            if (csr_we && csr_req_i.csr_index == csr_pkg::CSR_MEPC) begin
                mepc_q <= new_val;
            end else if (enter_trap_i) begin
                mepc_q <= csr_req_i.inst_addr;
            end
            if (csr_we && csr_req_i.csr_index == csr_pkg::CSR_MCAUSE) begin
                mcause_q <= new_val;
            end else if (enter_trap_i) begin
                mcause_q <= trap_cause;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec_q    <= '0;
            mie_q      <= '0;
            mscratch_q <= '0;
        end else if (csr_we) begin
            case (csr_req_i.csr_index)
                csr_pkg::CSR_MTVEC:    mtvec_q    <= {new_val[core_pkg::XLEN-1:2], 2'b00};
                csr_pkg::CSR_MIE:      mie_q      <= new_val & mix_mask;
                csr_pkg::CSR_MSCRATCH: mscratch_q <= new_val;
                default:               mscratch_q <= mscratch_q;
            endcase
        end
    end

    // timer pending tracks the clint
    always_ff @(posedge clk) begin
        if (rst) begin
            mip_q <= '0;
        end else if (csr_we && csr_req_i.csr_index == csr_pkg::CSR_MIP) begin
            mip_q <= new_val & mix_mask;
        end else if (mtip_i || mtimecmp_upd_i) begin
            mip_q[csr_pkg::MIX_MTI] <= mtip_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            if (csr_we && csr_req_i.csr_index == csr_pkg::CSR_MCYCLE) begin
                mcycle_q <= new_val;
            end else begin
                mcycle_q <= mcycle_inc;
            end
            if (csr_we && csr_req_i.csr_index == csr_pkg::CSR_MINSTRET) begin
                minstret_q <= new_val;
            end else if (csr_req_i.inst_valid) begin
                minstret_q <= minstret_inc;
            end
        end
    end

    assign irq_pending_o = mstatus_q[csr_pkg::MSTATUS_MIE] &
                           mie_q[csr_pkg::MIX_MTI] &
                           mip_q[csr_pkg::MIX_MTI];

    assign nxt_pc_o = enter_trap_i ? mtvec_q : mepc_q;

endmodule

/* rtl/mem_trap_ctrl.sv */
`timescale 1ns/1ps

module mem_trap_ctrl (
    input  logic inst_valid_i,
    input  logic ecall_i,
    input  logic ebreak_i,
    input  logic mret_i,
    input  logic irq_pending_i,
    output logic enter_trap_o,
    output logic leave_trap_o,
    output logic redirect_o
);

    logic exception;
    logic enter;
    logic leave;

    assign exception = ecall_i | ebreak_i;

    // interrupts and exceptions share one entry path
    assign enter = inst_valid_i & (exception | irq_pending_i);

    // entry wins over mret
    assign leave = inst_valid_i & mret_i & ~enter;

    assign enter_trap_o = enter;
    assign leave_trap_o = leave;
    assign redirect_o   = enter | leave;

endmodule

/* testbench/tb_csr_subsys.sv */
`timescale 1ns/1ps

module tb_csr_subsys;

    logic                        clk;
    logic                        rst;
    core_pkg::csr_req_t          csr_req;
    core_pkg::inst_flags_t       flags;
    core_pkg::clint_req_t        clint_req;
    logic [core_pkg::XLEN-1:0]   csr_rdata;
    logic [core_pkg::XLEN-1:0]   clint_rdata;
    logic                        redirect;
    logic [core_pkg::XLEN-1:0]   redirect_pc;

    logic [31:0] lfsr_state;
    logic [63:0] trap_vec;
    int          cycle_count = 0;

    csr_subsys_top uut (
        .clk           (clk),
        .rst           (rst),
        .csr_req_i     (csr_req),
        .flags_i       (flags),
        .clint_req_i   (clint_req),
        .csr_rdata_o   (csr_rdata),
        .clint_rdata_o (clint_rdata),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // the directed tests need under 100 cycles, 400 leaves ample margin
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= 400) begin
            $display("simulation timed out after %0d cycles", cycle_count);
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic rand_word(input int nbits, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value[i]   = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic clear_inputs();
        csr_req   = '0;
        flags     = '0;
        clint_req = '0;
    endtask

    // the unused source carries noise so a wrong source select shows up
    task automatic csr_access(input logic [11:0] idx, input csr_pkg::csr_op_t op,
                              input logic use_imm, input logic [63:0] value);
        logic [63:0] noise;
        rand_word(64, noise);
        csr_req.inst_valid = 1'b1;
        csr_req.csr_index  = idx;
        csr_req.csr_op     = op;
        csr_req.src_imm    = use_imm;
        csr_req.rs1_data   = use_imm ? noise : value;
        csr_req.imm_data   = use_imm ? value : noise;
        next_cycle();
        clear_inputs();
    endtask

    task automatic read_csr(input logic [11:0] idx, input logic valid,
                            output logic [63:0] value);
        csr_req.inst_valid = valid;
        csr_req.csr_index  = idx;
        #10;
        value = csr_rdata;
        next_cycle();
        clear_inputs();
    endtask

    task automatic expect_csr(input string name, input logic [11:0] idx,
                              input logic [63:0] exp);
        logic [63:0] value;
        read_csr(idx, 1'b0, value);
        check_value(name, value, exp);
    endtask

    // one valid instruction that must redirect to exp_pc
    task automatic present_inst(input logic ecall, input logic ebreak, input logic mret,
                                input logic [63:0] addr, input logic [63:0] exp_pc);
        csr_req.inst_valid = 1'b1;
        csr_req.csr_index  = csr_pkg::CSR_MSCRATCH;
        csr_req.inst_addr  = addr;
        flags.ecall        = ecall;
        flags.ebreak       = ebreak;
        flags.mret         = mret;
        #10;
        check_value("redirect_o", redirect, 1'b1);
        check_value("redirect_pc_o", redirect_pc, exp_pc);
        next_cycle();
        clear_inputs();
    endtask

    task automatic issue_plain(input int n);
        repeat (n) begin
            csr_req.inst_valid = 1'b1;
            csr_req.csr_index  = csr_pkg::CSR_MSCRATCH;
            #10;
            check_value("redirect_o", redirect, 1'b0);
            next_cycle();
            clear_inputs();
        end
    endtask

    task automatic test_mscratch_rmw();
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] c;
        logic [63:0] model;
        for (int mode = 0; mode < 2; mode++) begin
            // immediates are 5-bit zimm values
            rand_word(mode ? 5 : 64, a);
            rand_word(mode ? 5 : 64, b);
            rand_word(mode ? 5 : 64, c);
            csr_access(csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_RW, mode[0], a);
            model = a;
            expect_csr("mscratch", csr_pkg::CSR_MSCRATCH, model);
            csr_access(csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_RS, mode[0], b);
            model = model | b;
            expect_csr("mscratch", csr_pkg::CSR_MSCRATCH, model);
            csr_access(csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_RC, mode[0], c);
            model = model & ~c;
            expect_csr("mscratch", csr_pkg::CSR_MSCRATCH, model);
        end
    endtask

    task automatic test_constants_masks();
        expect_csr("misa", csr_pkg::CSR_MISA, (64'd2 << 62) | (64'd1 << 8));
        expect_csr("marchid", csr_pkg::CSR_MARCHID, 64'd1);
        expect_csr("mvendorid", csr_pkg::CSR_MVENDORID, 64'd0);
        expect_csr("mhartid", csr_pkg::CSR_MHARTID, 64'd0);
        csr_access(csr_pkg::CSR_MTVEC, csr_pkg::CSR_RW, 1'b0, '1);
        expect_csr("mtvec", csr_pkg::CSR_MTVEC, ~64'h3);
        csr_access(csr_pkg::CSR_MIE, csr_pkg::CSR_RW, 1'b0, '1);
        expect_csr("mie", csr_pkg::CSR_MIE, 64'h80);
    endtask

    task automatic test_ecall_mret();
        logic [63:0] epc;
        logic [63:0] status;
        rand_word(64, trap_vec);
        rand_word(64, epc);
        trap_vec[1:0] = 2'b00;
        epc[1:0]      = 2'b00;
        csr_access(csr_pkg::CSR_MSTATUS, csr_pkg::CSR_RS, 1'b0, 64'h8);
        csr_access(csr_pkg::CSR_MTVEC, csr_pkg::CSR_RW, 1'b0, trap_vec);
        present_inst(1'b1, 1'b0, 1'b0, epc, trap_vec);
        expect_csr("mepc", csr_pkg::CSR_MEPC, epc);
        expect_csr("mcause", csr_pkg::CSR_MCAUSE, 64'd11);
        read_csr(csr_pkg::CSR_MSTATUS, 1'b0, status);
        check_value("mstatus.mie", status[csr_pkg::MSTATUS_MIE], 1'b0);
        check_value("mstatus.mpie", status[csr_pkg::MSTATUS_MPIE], 1'b1);
        check_value("mstatus.mpp", status[csr_pkg::MSTATUS_MPP_LO +: 2], 2'b11);
        present_inst(1'b0, 1'b0, 1'b1, 64'h0, epc);
        read_csr(csr_pkg::CSR_MSTATUS, 1'b0, status);
        check_value("mstatus.mie", status[csr_pkg::MSTATUS_MIE], 1'b1);
        check_value("mstatus.mpp", status[csr_pkg::MSTATUS_MPP_LO +: 2], 2'b00);
        present_inst(1'b0, 1'b1, 1'b0, epc + 64'd4, trap_vec);
        expect_csr("mcause", csr_pkg::CSR_MCAUSE, 64'd3);
    endtask

    task automatic test_timer_irq();
        logic [63:0] now;
        logic [63:0] pending;
        int          waited;
        csr_access(csr_pkg::CSR_MSTATUS, csr_pkg::CSR_RS, 1'b0, 64'h8);
        csr_access(csr_pkg::CSR_MIE, csr_pkg::CSR_RS, 1'b0, 64'h80);
        clint_req.valid = 1'b1;
        clint_req.addr  = csr_pkg::CLINT_MTIME_ADDR;
        #10;
        now = clint_rdata;
        next_cycle();
        clint_req.we    = 1'b1;
        clint_req.addr  = csr_pkg::CLINT_MTIMECMP_ADDR;
        clint_req.wdata = now + 64'd10;
        next_cycle();
        // read the compare value back over the bus
        clint_req.we    = 1'b0;
        #10;
        check_value("clint_rdata_o", clint_rdata, now + 64'd10);
        next_cycle();
        clear_inputs();
        // poll with non-valid reads so the poll itself cannot take the interrupt
        waited  = 0;
        pending = '0;
        while (pending[7] !== 1'b1 && waited < 40) begin
            read_csr(csr_pkg::CSR_MIP, 1'b0, pending);
            waited++;
        end
        assert (pending[7] === 1'b1) else begin
            $display("mip timer bit did not set within 40 cycles of the mtimecmp write");
            $display("*** FAILED ***");
            $fatal(1);
        end
        present_inst(1'b0, 1'b0, 1'b0, 64'h8000_1000, trap_vec);
        expect_csr("mcause", csr_pkg::CSR_MCAUSE, (64'd1 << 63) | 64'd7);
        expect_csr("mepc", csr_pkg::CSR_MEPC, 64'h8000_1000);
    endtask

    task automatic test_counters();
        logic [63:0] first;
        logic [63:0] second;
        logic [63:0] wval;
        read_csr(csr_pkg::CSR_MCYCLE, 1'b0, first);
        idle_cycles(6);
        read_csr(csr_pkg::CSR_MCYCLE, 1'b0, second);
        check_value("mcycle delta", second - first, 64'd7);
        read_csr(csr_pkg::CSR_MINSTRET, 1'b1, first);
        issue_plain(5);
        read_csr(csr_pkg::CSR_MINSTRET, 1'b1, second);
        check_value("minstret delta", second - first, 64'd6);
        rand_word(64, wval);
        csr_access(csr_pkg::CSR_MCYCLE, csr_pkg::CSR_RW, 1'b0, wval);
        idle_cycles(3);
        expect_csr("mcycle", csr_pkg::CSR_MCYCLE, wval + 64'd3);
    endtask

    initial begin
        rst        = 1'b1;
        lfsr_state = 32'h6019bc3a;
        trap_vec   = '0;
        clear_inputs();
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        test_mscratch_rmw();
        test_constants_masks();
        test_ecall_mret();
        test_timer_irq();
        test_counters();
        $display("*** PASSED ***");
        $finish;
    end

endmodule
